// ==== list.f ====
+incdir+common
+incdir+dv
common/rtcBusPkg.sv
common/rtcRegPkg.sv
rtcApbif/rtcAddrDecode.sv
rtcApbif/rtcRegBank.sv
rtcApbif/rtcReadMux.sv
source/rtcTop.sv
dv/tbRtc.sv

// ==== run.sh ====
#!/bin/bash
# Compile and run the RTC testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --top-module tbRtc -f list.f -o simRtc
if [ $? -ne 0 ]; then
  echo "Verilator compile step returned an error"
  exit 1
fi

./obj_dir/simRtc > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if grep -q "Test failed" sim.log; then
  exit 1
fi
exit 0

// ==== dv/tbRtcTable.svh ====
// Stimulus and expected values of the RTC testbench
// Columns are op, address or port id, data, random flag and expected value
// Data is the write word, the input value, the idle count or the port wait limit
// Status data bit 0 is RTCRIS, bit 1 RTCMIS, bit 2 RawIntSync
// A set random flag writes a fresh word, or expects the last one written

task loadTable();
  // Reset state
  addRow(opRead,   `RTC_ADDR_MR,   32'h0, 1'b0, 32'h0);
  addRow(opRead,   `RTC_ADDR_LR,   32'h0, 1'b0, 32'h0);
  addRow(opRead,   `RTC_ADDR_CR,   32'h0, 1'b0, 32'h0);
  addRow(opRead,   `RTC_ADDR_IMSC, 32'h0, 1'b0, 32'h0);
  addRow(opPort,   portMr,         32'h0, 1'b0, 32'h0);
  addRow(opPort,   portLr,         32'h0, 1'b0, 32'h0);
  addRow(opPort,   portEn,         32'h0, 1'b0, 32'h0);
  addRow(opPort,   portImsc,       32'h0, 1'b0, 32'h0);
  addRow(opPort,   portIcr,        32'h0, 1'b0, 32'h0);
  // Match and load, random words
  addRow(opWrite,  `RTC_ADDR_MR,   32'h0, 1'b1, 32'h0);
  addRow(opRead,   `RTC_ADDR_MR,   32'h0, 1'b1, 32'h0);
  addRow(opPort,   portMr,         32'h0, 1'b1, 32'h0);
  addRow(opNoSel,  `RTC_ADDR_MR,   32'hFFFF_FFFF, 1'b0, 32'h0);  // Must be ignored
  addRow(opRead,   `RTC_ADDR_MR,   32'h0, 1'b1, 32'h0);
  addRow(opWrite,  `RTC_ADDR_LR,   32'h0, 1'b1, 32'h0);
  addRow(opRead,   `RTC_ADDR_LR,   32'h0, 1'b1, 32'h0);
  addRow(opPort,   portLr,         32'h0, 1'b1, 32'h0);
  // Control and mask keep bit 0 only
  addRow(opWrite,  `RTC_ADDR_CR,   32'hFFFF_FFFF, 1'b0, 32'h0);
  addRow(opRead,   `RTC_ADDR_CR,   32'h0, 1'b0, 32'h1);
  addRow(opPort,   portEn,         32'h0, 1'b0, 32'h1);
  addRow(opNoSel,  `RTC_ADDR_CR,   32'h0, 1'b0, 32'h0);
  addRow(opRead,   `RTC_ADDR_CR,   32'h0, 1'b0, 32'h1);
  addRow(opWrite,  `RTC_ADDR_IMSC, 32'hFFFF_FFFF, 1'b0, 32'h0);
  addRow(opRead,   `RTC_ADDR_IMSC, 32'h0, 1'b0, 32'h1);
  addRow(opPort,   portImsc,       32'h0, 1'b0, 32'h1);
  addRow(opWrite,  `RTC_ADDR_IMSC, 32'hFFFF_FFFE, 1'b0, 32'h0);
  addRow(opRead,   `RTC_ADDR_IMSC, 32'h0, 1'b0, 32'h0);
  addRow(opPort,   portImsc,       32'h0, 1'b0, 32'h0);
  // Read-only sources
  addRow(opSetDr,  10'h0,          32'h1234_5678, 1'b0, 32'h0);
  addRow(opStatus, 10'h0,          32'h1, 1'b0, 32'h0);  // RIS high, MIS low
  addRow(opRead,   `RTC_ADDR_DR,   32'h0, 1'b0, 32'h1234_5678);
  addRow(opRead,   `RTC_ADDR_RIS,  32'h0, 1'b0, 32'h1);
  addRow(opRead,   `RTC_ADDR_MIS,  32'h0, 1'b0, 32'h0);
  addRow(opStatus, 10'h0,          32'h2, 1'b0, 32'h0);  // RIS low, MIS high
  addRow(opRead,   `RTC_ADDR_RIS,  32'h0, 1'b0, 32'h0);
  addRow(opRead,   `RTC_ADDR_MIS,  32'h0, 1'b0, 32'h1);
  addRow(opWrite,  `RTC_ADDR_DR,   32'hFFFF_FFFF, 1'b0, 32'h0);
  addRow(opWrite,  `RTC_ADDR_RIS,  32'hFFFF_FFFF, 1'b0, 32'h0);
  addRow(opWrite,  `RTC_ADDR_MIS,  32'hFFFF_FFFF, 1'b0, 32'h0);
  addRow(opRead,   `RTC_ADDR_DR,   32'h0, 1'b0, 32'h1234_5678);
  addRow(opPort,   portImsc,       32'h0, 1'b0, 32'h0);  // Still masked off
  // Interrupt clear follows RawIntSync
  addRow(opStatus, 10'h0,          32'h4, 1'b0, 32'h0);
  addRow(opPort,   portIcr,        32'h0, 1'b0, 32'h0);  // No request before the write
  addRow(opWrite,  `RTC_ADDR_ICR,  32'h1, 1'b0, 32'h0);
  addRow(opPort,   portIcr,        32'h0, 1'b0, 32'h1);
  addRow(opIdle,   10'h0,          32'h4, 1'b0, 32'h0);
  addRow(opPort,   portIcr,        32'h0, 1'b0, 32'h1);
  addRow(opStatus, 10'h0,          32'h0, 1'b0, 32'h0);
  addRow(opPort,   portIcr,        32'h2, 1'b0, 32'h0);  // Within two cycles
  // Identification bytes and holes
  addRow(opRead,   `RTC_ADDR_PID0, 32'h0, 1'b0, {24'h0, `RTC_PERIPHID0});
  addRow(opRead,   `RTC_ADDR_PID1, 32'h0, 1'b0, {24'h0, `RTC_PERIPHID1});
  addRow(opRead,   `RTC_ADDR_PID2, 32'h0, 1'b0, {24'h0, `RTC_REVISION, `RTC_PERIPHID2});
  addRow(opRead,   `RTC_ADDR_PID3, 32'h0, 1'b0, {24'h0, `RTC_PERIPHID3});
  addRow(opRead,   `RTC_ADDR_CID0, 32'h0, 1'b0, {24'h0, `RTC_CELLID0});
  addRow(opRead,   `RTC_ADDR_CID1, 32'h0, 1'b0, {24'h0, `RTC_CELLID1});
  addRow(opRead,   `RTC_ADDR_CID2, 32'h0, 1'b0, {24'h0, `RTC_CELLID2});
  addRow(opRead,   `RTC_ADDR_CID3, 32'h0, 1'b0, {24'h0, `RTC_CELLID3});
  addRow(opRead,   10'h010,        32'h0, 1'b0, 32'h0);  // Unmapped
  addRow(opRead,   `RTC_ADDR_ICR,  32'h0, 1'b0, 32'h0);  // Write only
endtask

// ==== dv/tbRtc.sv ====
// Testbench of the RTC APB register interface
// Inputs change 1 ns after the rising edge, outputs are sampled mid cycle
// One idle cycle separates APB transfers, no wait states are expected
// Rows come from tbRtcTable.svh and run in order
`timescale 1ns/1ns

`include "rtc_defs.svh"

module tbRtc;

  localparam int clkPeriod    = 10;
  localparam int resetCycles  = 5;
  localparam int cyclesPerRow = 10;  // Watchdog budget per table row

  // Row operations
  localparam logic [3:0] opWrite  = 4'd0;
  localparam logic [3:0] opRead   = 4'd1;
  localparam logic [3:0] opPort   = 4'd2;  // Check an output port
  localparam logic [3:0] opSetDr  = 4'd3;  // Drive RTCDR
  localparam logic [3:0] opStatus = 4'd4;  // Drive RIS, MIS, RawIntSync
  localparam logic [3:0] opIdle   = 4'd5;
  localparam logic [3:0] opNoSel  = 4'd6;  // Write cycle with PSEL low

  // Port ids for opPort, carried in the address column
  localparam logic [`RTC_ADDR_W-1:0] portMr   = 10'd0;
  localparam logic [`RTC_ADDR_W-1:0] portLr   = 10'd1;
  localparam logic [`RTC_ADDR_W-1:0] portEn   = 10'd2;
  localparam logic [`RTC_ADDR_W-1:0] portImsc = 10'd3;
  localparam logic [`RTC_ADDR_W-1:0] portIcr  = 10'd4;

  typedef struct packed
  {
    logic [3:0]             op;
    logic [`RTC_ADDR_W-1:0] addr;
    logic [`RTC_DATA_W-1:0] data;  // Write word, input value or cycle count
    logic                   rnd;   // Use a random word
    logic [`RTC_DATA_W-1:0] expV;
  } tableRow_t;

  logic PCLK, PRESETn, PSEL, PENABLE, PWRITE;
  logic [`RTC_ADDR_W-1:0] PADDR;
  logic [`RTC_DATA_W-1:0] PWDATA, RTCDR, PRDATA, RTCMR, RTCLR;
  logic RTCRIS, RTCMIS, RawIntSync;
  logic WrenRTCMR, WrenRTCLR, RTCEn, RTCIMSC, RTCICR;

  tableRow_t rows[$];
  logic      tableReady = 1'b0;
  integer    seed       = 99;
  logic [`RTC_DATA_W-1:0] lastRnd = '0;  // Last random word written
  int        errorCount = 0;
  int        checkCount = 0;

  rtcTop u_dut (.*);

  task automatic addRow(input logic [3:0] op, input logic [`RTC_ADDR_W-1:0] addr,
                        input logic [`RTC_DATA_W-1:0] data, input logic rnd,
                        input logic [`RTC_DATA_W-1:0] expV);
    rows.push_back('{op: op, addr: addr, data: data, rnd: rnd, expV: expV});
  endtask

  `include "tbRtcTable.svh"

  initial
  begin
    PCLK = 1'b0;
    forever #(clkPeriod / 2) PCLK = ~PCLK;
  end

  // ------------------------------
  // Checks
  // ------------------------------
  task checkValue(input string name, input logic [`RTC_DATA_W-1:0] expV,
                  input logic [`RTC_DATA_W-1:0] actV);
    checkCount++;
    if (actV !== expV)
    begin
      errorCount++;
      $display("Error at %0t ns: %s expected 0x%08h, got 0x%08h", $time, name, expV, actV);
    end
  endtask

  task checkStrobes(input logic expMr, input logic expLr);
    checkValue("WrenRTCMR", {31'b0, expMr}, {31'b0, WrenRTCMR});
    checkValue("WrenRTCLR", {31'b0, expLr}, {31'b0, WrenRTCLR});
  endtask

  function automatic logic [`RTC_DATA_W-1:0] portValue(input logic [`RTC_ADDR_W-1:0] sel);
    case (sel)
      portMr:   return RTCMR;
      portLr:   return RTCLR;
      portEn:   return {31'b0, RTCEn};
      portImsc: return {31'b0, RTCIMSC};
      default:  return {31'b0, RTCICR};
    endcase
  endfunction

  function automatic string portName(input logic [`RTC_ADDR_W-1:0] sel);
    case (sel)
      portMr:   return "RTCMR";
      portLr:   return "RTCLR";
      portEn:   return "RTCEn";
      portImsc: return "RTCIMSC";
      default:  return "RTCICR";
    endcase
  endfunction

  function automatic string opName(input logic [3:0] op);
    case (op)
      opWrite:  return "write";
      opRead:   return "read";
      opPort:   return "port check";
      opSetDr:  return "set RTCDR";
      opStatus: return "set status";
      opIdle:   return "idle";
      opNoSel:  return "unselected write";
      default:  return "unknown";
    endcase
  endfunction

  // Port may need a few cycles to settle, bounded by maxWait
  task checkPort(input logic [`RTC_ADDR_W-1:0] sel, input logic [`RTC_DATA_W-1:0] expV,
                 input int maxWait);
    logic [`RTC_DATA_W-1:0] act;
    int                     waited;
    waited = 0;
    @(posedge PCLK);
    #5;
    act = portValue(sel);
    while (act !== expV && waited < maxWait)
    begin
      @(posedge PCLK);
      #5;
      act = portValue(sel);
      waited++;
    end
    checkValue(portName(sel), expV, act);
  endtask

  // ------------------------------
  // APB driver
  // ------------------------------
  task driveIdle();
    PSEL    = 1'b0;
    PENABLE = 1'b0;
    PWRITE  = 1'b0;
    PADDR   = '0;
    PWDATA  = '0;
  endtask

  task apbWrite(input logic [`RTC_ADDR_W-1:0] addr, input logic [`RTC_DATA_W-1:0] data,
                input logic sel);
    @(posedge PCLK);
    #1;
    PSEL    = sel;  // Setup phase
    PENABLE = 1'b0;
    PWRITE  = 1'b1;
    PADDR   = addr;
    PWDATA  = data;
    #4;
    checkStrobes(1'b0, 1'b0);
    @(posedge PCLK);
    #1;
    PENABLE = 1'b1;  // Access phase
    #4;
    checkStrobes(sel && addr == `RTC_ADDR_MR, sel && addr == `RTC_ADDR_LR);
    @(posedge PCLK);
    #1;
    driveIdle();
  endtask

  task apbRead(input logic [`RTC_ADDR_W-1:0] addr, output logic [`RTC_DATA_W-1:0] data);
    @(posedge PCLK);
    #1;
    PSEL    = 1'b1;
    PENABLE = 1'b0;
    PWRITE  = 1'b0;
    PADDR   = addr;
    #4;
    checkStrobes(1'b0, 1'b0);
    @(posedge PCLK);
    #1;
    PENABLE = 1'b1;
    #4;
    data = PRDATA;  // Registered at end of setup
    checkStrobes(1'b0, 1'b0);
    @(posedge PCLK);
    #1;
    driveIdle();
  endtask

  // ------------------------------
  // Row execution
  // ------------------------------
  task runRow(input tableRow_t row);
    logic [`RTC_DATA_W-1:0] expV;
    logic [`RTC_DATA_W-1:0] rdVal;
    logic [`RTC_DATA_W-1:0] wrVal;
    expV  = row.rnd ? lastRnd : row.expV;
    wrVal = row.data;
    case (row.op)
      opWrite:
      begin
        if (row.rnd)
        begin
          lastRnd = $random(seed);
          wrVal   = lastRnd;
        end
        apbWrite(row.addr, wrVal, 1'b1);
      end
      opRead:
      begin
        apbRead(row.addr, rdVal);
        checkValue("PRDATA", expV, rdVal);
      end
      opPort:   checkPort(row.addr, expV, row.data);
      opSetDr:
      begin
        @(posedge PCLK);
        #1;
        RTCDR = row.data;
      end
      opStatus:
      begin
        @(posedge PCLK);
        #1;
        RTCRIS     = row.data[0];
        RTCMIS     = row.data[1];
        RawIntSync = row.data[2];
      end
      opIdle:   repeat (row.data) @(posedge PCLK);
      opNoSel:  apbWrite(row.addr, row.data, 1'b0);
      default:
      begin
        errorCount++;
        $display("Table row has an unknown operation code %0d", row.op);
      end
    endcase
  endtask

  // ------------------------------
  // Watchdog
  // ------------------------------
  initial
  begin
    int limitNs;
    wait (tableReady);
    limitNs = (rows.size() * cyclesPerRow + resetCycles + 2) * clkPeriod;
    #(limitNs);
    $display("Watchdog expired, the table did not finish within %0d ns", limitNs);
    $display("Test failed");
    $finish;
  end

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial
  begin
    driveIdle();
    RTCDR      = '0;
    RTCRIS     = 1'b0;
    RTCMIS     = 1'b0;
    RawIntSync = 1'b0;
    PRESETn    = 1'b0;
    loadTable();
    tableReady = 1'b1;
    repeat (resetCycles) @(posedge PCLK);
    #1;
    PRESETn = 1'b1;
    for (int i = 0; i < rows.size(); i++)
    begin
      runRow(rows[i]);
      $display("Row %0d %s done, %0d errors so far", i, opName(rows[i].op), errorCount);
    end
    $display("Rows %0d, checks %0d, errors %0d", rows.size(), checkCount, errorCount);
    if (errorCount == 0)
    begin
      $display("Test completed successfully");
    end
    else
    begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== source/rtcTop.sv ====
// APB register interface of the RTC peripheral
// Zero wait state APB slave with no PREADY or PSLVERR
// Counter, match logic and interrupt generation sit outside this block
// RawIntSync must be synchronous to PCLK
`timescale 1ns/1ns

`include "rtc_defs.svh"

module rtcTop
(
  input  logic                    PCLK,
  input  logic                    PRESETn,     // Async, active low
  input  logic                    PSEL,
  input  logic                    PENABLE,
  input  logic                    PWRITE,
  input  logic [`RTC_ADDR_W-1:0]  PADDR,       // Word address, bits 11:2
  input  logic [`RTC_DATA_W-1:0]  PWDATA,
  input  logic [`RTC_DATA_W-1:0]  RTCDR,       // Current count
  input  logic                    RTCRIS,      // Raw interrupt status
  input  logic                    RTCMIS,      // Masked interrupt status
  input  logic                    RawIntSync,  // Synchronised raw interrupt
  output logic [`RTC_DATA_W-1:0]  PRDATA,
  output logic [`RTC_DATA_W-1:0]  RTCMR,       // Match value
  output logic [`RTC_DATA_W-1:0]  RTCLR,       // Load value
  output logic                    WrenRTCMR,   // Match write in progress
  output logic                    WrenRTCLR,   // Load write in progress
  output logic                    RTCEn,       // Counter enable
  output logic                    RTCIMSC,     // Interrupt mask
  output logic                    RTCICR       // Interrupt clear request
);

  rtcBusPkg::apbReq_t       apbReq;    // Packed APB pins
  rtcRegPkg::regWrStrobe_t  wrStrobe;
  rtcRegPkg::regRdSel_t     rdSel;
  rtcRegPkg::regState_t     regs;
  logic [`RTC_DATA_W-1:0]   wrData;    // Gated write data

  // ------------------------------
  // APB request
  // ------------------------------
  assign apbReq = '{sel: PSEL, enable: PENABLE, write: PWRITE, addr: PADDR, wdata: PWDATA};

  rtcAddrDecode uAddrDecode
  (
    .apbReq   (apbReq),
    .wrStrobe (wrStrobe),
    .rdSel    (rdSel),
    .wrData   (wrData)
  );

  rtcRegBank uRegBank
  (
    .PCLK       (PCLK),
    .PRESETn    (PRESETn),
    .wrStrobe   (wrStrobe),
    .wrData     (wrData),
    .RawIntSync (RawIntSync),
    .regs       (regs)
  );

  rtcReadMux uReadMux
  (
    .PCLK    (PCLK),
    .PRESETn (PRESETn),
    .rdSel   (rdSel),
    .regs    (regs),
    .RTCDR   (RTCDR),
    .RTCRIS  (RTCRIS),
    .RTCMIS  (RTCMIS),
    .PRDATA  (PRDATA)
  );

  // ------------------------------
  // Register outputs
  // ------------------------------
  assign RTCMR     = regs.matchWord;
  assign RTCLR     = regs.loadWord;
  assign RTCEn     = regs.enable;
  assign RTCIMSC   = regs.mask;
  assign RTCICR    = regs.intClr;
  assign WrenRTCMR = wrStrobe.match;  // Combinational, access phase only
  assign WrenRTCLR = wrStrobe.load;

endmodule

// ==== rtcApbif/rtcReadMux.sv ====
// Read data path of the RTC
// PRDATA is registered at the end of the setup phase
// It is valid throughout the access phase and zero in any other cycle
// Narrow sources are zero extended to a full word
`timescale 1ns/1ns

`include "rtc_defs.svh"

module rtcReadMux
(
  input  logic                    PCLK,
  input  logic                    PRESETn,  // Async, active low
  input  rtcRegPkg::regRdSel_t    rdSel,    // From decoder, setup phase only
  input  rtcRegPkg::regState_t    regs,     // From register bank
  input  logic [`RTC_DATA_W-1:0]  RTCDR,    // Counter value
  input  logic                    RTCRIS,   // Raw interrupt status
  input  logic                    RTCMIS,   // Masked interrupt status
  output logic [`RTC_DATA_W-1:0]  PRDATA    // APB read data
);

  logic [`RTC_DATA_W-1:0] nextRdata;  // D-input of PRDATA

  // Single status or control bit into bit 0
  function automatic logic [`RTC_DATA_W-1:0] extBit(input logic b);
    return {{(`RTC_DATA_W-1){1'b0}}, b};
  endfunction

  // ID byte into the low byte
  function automatic logic [`RTC_DATA_W-1:0] extByte(input logic [7:0] b);
    return {{(`RTC_DATA_W-8){1'b0}}, b};
  endfunction

  // ------------------------------
  // Source select
  // ------------------------------
  always_comb
  begin
    case (rdSel)
      rtcRegPkg::rdData:  nextRdata = RTCDR;
      rtcRegPkg::rdMatch: nextRdata = regs.matchWord;
      rtcRegPkg::rdLoad:  nextRdata = regs.loadWord;
      rtcRegPkg::rdCtrl:  nextRdata = extBit(regs.enable);
      rtcRegPkg::rdMask:  nextRdata = extBit(regs.mask);
      rtcRegPkg::rdRis:   nextRdata = extBit(RTCRIS);
      rtcRegPkg::rdMis:   nextRdata = extBit(RTCMIS);
      rtcRegPkg::rdPid0:  nextRdata = extByte(`RTC_PERIPHID0);
      rtcRegPkg::rdPid1:  nextRdata = extByte(`RTC_PERIPHID1);
      // Revision in the upper nibble
      rtcRegPkg::rdPid2:  nextRdata = extByte({`RTC_REVISION, `RTC_PERIPHID2});
      rtcRegPkg::rdPid3:  nextRdata = extByte(`RTC_PERIPHID3);
      rtcRegPkg::rdCid0:  nextRdata = extByte(`RTC_CELLID0);
      rtcRegPkg::rdCid1:  nextRdata = extByte(`RTC_CELLID1);
      rtcRegPkg::rdCid2:  nextRdata = extByte(`RTC_CELLID2);
      rtcRegPkg::rdCid3:  nextRdata = extByte(`RTC_CELLID3);
      default:            nextRdata = '0;  // rdNone
    endcase
  end

  // ------------------------------
  // Read data register
  // ------------------------------
  // Returns to zero after every access
  always_ff @(posedge PCLK or negedge PRESETn)
  begin
    if (!PRESETn)
    begin
      PRDATA <= '0;
    end
    else
    begin
      PRDATA <= nextRdata;
    end
  end

endmodule

// ==== rtcApbif/rtcRegBank.sv ====
// Functional registers of the RTC
// Registers load on the edge that ends the access phase of a write
// Control, mask and clear take bit 0 of the write data
// The interrupt clear bit only lives while RawIntSync is high
// RawIntSync must already be synchronised to PCLK
// Everything resets to zero on PRESETn
`timescale 1ns/1ns

`include "rtc_defs.svh"

module rtcRegBank
(
  input  logic                     PCLK,
  input  logic                     PRESETn,     // Async, active low
  input  rtcRegPkg::regWrStrobe_t  wrStrobe,    // From decoder
  input  logic [`RTC_DATA_W-1:0]   wrData,      // Gated PWDATA
  input  logic                     RawIntSync,  // Raw interrupt in PCLK domain
  output rtcRegPkg::regState_t     regs         // Current register contents
);

  rtcRegPkg::regState_t nextRegs;  // D-input of the whole bank

  // ------------------------------
  // Next state
  // ------------------------------
  always_comb
  begin
    nextRegs = regs;  // Hold by default

    // Match register
    if (wrStrobe.match)
    begin
      nextRegs.matchWord = wrData;
    end

    // Load register
    if (wrStrobe.load)
    begin
      nextRegs.loadWord = wrData;
    end

    // Control register, only the enable bit exists
    if (wrStrobe.ctrl)
    begin
      nextRegs.enable = wrData[0];
    end

    // Interrupt mask
    if (wrStrobe.mask)
    begin
      nextRegs.mask = wrData[0];
    end

    // Interrupt clear
    // A write always wins over the self clear
    // Writing 0 drops a pending request immediately
    // With no write the bit falls once the raw interrupt has gone
    if (wrStrobe.intClr)
    begin
      nextRegs.intClr = wrData[0];
    end
    else if (!RawIntSync)
    begin
      nextRegs.intClr = 1'b0;  // Interrupt gone so nothing to clear
    end
  end

  // ------------------------------
  // State
  // ------------------------------
  always_ff @(posedge PCLK or negedge PRESETn)
  begin
    if (!PRESETn)
    begin
      regs <= '0;  // Counter disabled, interrupt masked
    end
    else
    begin
      regs <= nextRegs;
    end
  end

  // Note the clear bit sees RawIntSync one edge late
  // So RTCICR falls one cycle after the raw interrupt is seen low
  // The counter side is expected to tolerate that extra cycle

endmodule

// ==== rtcApbif/rtcAddrDecode.sv ====
// APB address and phase decoder of the RTC
// Purely combinational, no state
// Write strobes are valid in the access phase of a write
// Read select is valid in the setup phase of a read
// Unmapped addresses give no strobe and rdNone
`timescale 1ns/1ns

`include "rtc_defs.svh"

module rtcAddrDecode
(
  input  rtcBusPkg::apbReq_t       apbReq,    // Packed APB pins
  output rtcRegPkg::regWrStrobe_t  wrStrobe,  // To register bank
  output rtcRegPkg::regRdSel_t     rdSel,     // To read mux
  output logic [`RTC_DATA_W-1:0]   wrData     // Gated PWDATA
);

  logic [`RTC_ADDR_W-1:0] gatedAddr;  // Zero while not selected
  logic                   wrPhase;    // Access phase of a write
  logic                   rdPhase;    // Setup phase of a read

  // ------------------------------
  // Bus gating
  // ------------------------------
  // Keeps internal buses quiet while another slave is addressed
  assign gatedAddr = apbReq.sel ? apbReq.addr : '0;
  assign wrData    = (apbReq.sel & apbReq.write) ? apbReq.wdata : '0;

  // Phase qualifiers
  assign wrPhase = apbReq.sel & apbReq.enable & apbReq.write;
  assign rdPhase = apbReq.sel & ~apbReq.enable & ~apbReq.write;

  // ------------------------------
  // Write strobes
  // ------------------------------
  // Read-only and ID addresses have no strobe at all
  assign wrStrobe.match  = wrPhase & (gatedAddr == `RTC_ADDR_MR);
  assign wrStrobe.load   = wrPhase & (gatedAddr == `RTC_ADDR_LR);
  assign wrStrobe.ctrl   = wrPhase & (gatedAddr == `RTC_ADDR_CR);
  assign wrStrobe.mask   = wrPhase & (gatedAddr == `RTC_ADDR_IMSC);
  assign wrStrobe.intClr = wrPhase & (gatedAddr == `RTC_ADDR_ICR);

  // ------------------------------
  // Read select
  // ------------------------------
  always_comb
  begin
    rdSel = rtcRegPkg::rdNone;  // Default covers idle, writes and holes
    if (rdPhase)
    begin
      case (gatedAddr)
        `RTC_ADDR_DR:   rdSel = rtcRegPkg::rdData;
        `RTC_ADDR_MR:   rdSel = rtcRegPkg::rdMatch;
        `RTC_ADDR_LR:   rdSel = rtcRegPkg::rdLoad;
        `RTC_ADDR_CR:   rdSel = rtcRegPkg::rdCtrl;
        `RTC_ADDR_IMSC: rdSel = rtcRegPkg::rdMask;
        `RTC_ADDR_RIS:  rdSel = rtcRegPkg::rdRis;
        `RTC_ADDR_MIS:  rdSel = rtcRegPkg::rdMis;
        // ICR is write only and reads as zero
        `RTC_ADDR_PID0: rdSel = rtcRegPkg::rdPid0;
        `RTC_ADDR_PID1: rdSel = rtcRegPkg::rdPid1;
        `RTC_ADDR_PID2: rdSel = rtcRegPkg::rdPid2;
        `RTC_ADDR_PID3: rdSel = rtcRegPkg::rdPid3;
        `RTC_ADDR_CID0: rdSel = rtcRegPkg::rdCid0;
        `RTC_ADDR_CID1: rdSel = rtcRegPkg::rdCid1;
        `RTC_ADDR_CID2: rdSel = rtcRegPkg::rdCid2;
        `RTC_ADDR_CID3: rdSel = rtcRegPkg::rdCid3;
        default:        rdSel = rtcRegPkg::rdNone;
      endcase
    end
  end

endmodule

// ==== common/rtcRegPkg.sv ====
// Register side types of the RTC peripheral
// Strobes and read select come from the address decoder
// Register state comes from the register bank and feeds the read mux and the ports
// Control, mask and clear hold only bit 0 of the written word
package rtcRegPkg;

  `include "rtc_defs.svh"

  // ------------------------------
  // Write strobes
  // ------------------------------
  // One-hot, each high for the access phase of a write to its address
  typedef struct packed
  {
    logic match;   // RTCMR
    logic load;    // RTCLR
    logic ctrl;    // RTCCR
    logic mask;    // RTCIMSC
    logic intClr;  // RTCICR
  } regWrStrobe_t;

  // ------------------------------
  // Read select
  // ------------------------------
  // Valid during the setup phase of a read, rdNone otherwise
  typedef enum logic [4:0]
  {
    rdNone  = 5'd0,
    rdData  = 5'd1,   // RTCDR input
    rdMatch = 5'd2,
    rdLoad  = 5'd3,
    rdCtrl  = 5'd4,
    rdMask  = 5'd5,
    rdRis   = 5'd6,   // Raw status input
    rdMis   = 5'd7,   // Masked status input
    rdPid0  = 5'd8,
    rdPid1  = 5'd9,
    rdPid2  = 5'd10,  // Carries the revision
    rdPid3  = 5'd11,
    rdCid0  = 5'd12,
    rdCid1  = 5'd13,
    rdCid2  = 5'd14,
    rdCid3  = 5'd15
  } regRdSel_t;

  // ------------------------------
  // Register contents
  // ------------------------------
  typedef struct packed
  {
    logic [`RTC_DATA_W-1:0] matchWord;  // Compared against the counter outside
    logic [`RTC_DATA_W-1:0] loadWord;   // Loaded into the counter outside
    logic                   enable;     // RTCEn
    logic                   mask;       // RTCIMSC
    logic                   intClr;     // RTCICR, self clearing
  } regState_t;

endpackage

// ==== common/rtcBusPkg.sv ====
// Bus side types of the RTC peripheral
// One APB transfer as seen at the slave pins
// The peripheral has no wait states so PREADY and PSLVERR are not carried
// PADDR is already trimmed to the word address
package rtcBusPkg;

  `include "rtc_defs.svh"

  // ------------------------------
  // APB request
  // ------------------------------
  // Field order follows the pin order of the slave port
  // The decoder is the only consumer of this struct
  typedef struct packed
  {
    logic                   sel;     // PSEL
    logic                   enable;  // PENABLE, high in access phase
    logic                   write;   // PWRITE, low for reads
    logic [`RTC_ADDR_W-1:0] addr;    // PADDR[11:2]
    logic [`RTC_DATA_W-1:0] wdata;   // PWDATA, only valid on writes
  } apbReq_t;

  // Setup phase    sel=1 enable=0
  // Access phase   sel=1 enable=1
  // Idle           sel=0

  // Address stays stable across both phases of a transfer
  // Write data only matters in the access phase
  // Total width is 3 control bits plus address plus data

endpackage

// ==== common/rtc_defs.svh ====
// Register map and identification constants for the RTC APB interface
// All addresses are word addresses matching PADDR[11:2]
// Byte lanes are not decoded and every access is a full word
// The revision nibble is reported in the upper half of identification register 2
`ifndef RTC_DEFS_SVH
`define RTC_DEFS_SVH

// ------------------------------
// Bus widths
// ------------------------------
// APB data word and wide registers
`define RTC_DATA_W 32
// Word address bits 11 down to 2
`define RTC_ADDR_W 10

// ------------------------------
// Functional register map
// ------------------------------
`define RTC_ADDR_DR   10'h000
`define RTC_ADDR_MR   10'h001
`define RTC_ADDR_LR   10'h002
`define RTC_ADDR_CR   10'h003
`define RTC_ADDR_IMSC 10'h004
`define RTC_ADDR_RIS  10'h005
`define RTC_ADDR_MIS  10'h006
`define RTC_ADDR_ICR  10'h007

// Identification block at byte offsets 0xFE0 to 0xFFC
`define RTC_ADDR_PID0 10'h3F8
`define RTC_ADDR_PID1 10'h3F9
`define RTC_ADDR_PID2 10'h3FA
`define RTC_ADDR_PID3 10'h3FB
`define RTC_ADDR_CID0 10'h3FC
`define RTC_ADDR_CID1 10'h3FD
`define RTC_ADDR_CID2 10'h3FE
`define RTC_ADDR_CID3 10'h3FF

// ------------------------------
// Identification values
// ------------------------------
`define RTC_PERIPHID0 8'h31
`define RTC_PERIPHID1 8'h10
// Lower nibble only, revision fills the top
`define RTC_PERIPHID2 4'h4
`define RTC_PERIPHID3 8'h00
`define RTC_CELLID0   8'h0D
`define RTC_CELLID1   8'hF0
`define RTC_CELLID2   8'h05
`define RTC_CELLID3   8'hB1
`define RTC_REVISION  4'h1

`endif
